/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_cache -Mdir obj_dir
	./obj_dir/Vtb_cache | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* cache/cache_beat_cnt.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_beat_cnt (
  input  wire logic                        clk_i,
  input  wire logic                        rst_i,
  input  wire logic                        ram_init_i,
  input  wire logic                        clr_i,
  input  wire logic                        inc_i,
  output logic [cache_pkg::idx_w-1:0]      cnt_o,
  output logic                             last_o
);

  logic [cache_pkg::idx_w-1:0] cnt_q;

  // Down over all rows in init, up over beats afterwards
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cnt_q <= '1;
    end else if (clr_i) begin
      cnt_q <= '0;
    end else if (inc_i) begin
      if (ram_init_i) begin
        cnt_q <= cnt_q - 1'b1;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign cnt_o  = cnt_q;
  assign last_o = ram_init_i ? (cnt_q == '0) : (cnt_q == 3);  // Last row or beat 3

endmodule

`default_nettype wire

/* cache/cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
  input  wire logic                        clk_i,
  input  wire logic                        rst_i,
  input  wire cache_pkg::sbus_req_t        req_i,
  input  wire cache_pkg::cache_line_t      rd_line_i,
  input  wire logic [cache_pkg::idx_w-1:0] cnt_i,
  input  wire logic                        cnt_last_i,
  output logic                             cnt_clr_o,
  output logic                             cnt_inc_o,
  output cache_pkg::line_op_e              op_o,
  output logic                             ram_we_o,
  output logic                             ram_init_o,
  output cache_pkg::mbus_req_t             mreq_o,
  input  wire logic [31:0]                 wdat_i,
  input  wire logic                        mack_i,
  output logic                             ack_o,
  output logic [1:0]                       status_o
);
  import cache_pkg::*;

  typedef enum logic [3:0] {
    st_init,
    st_idle,
    st_lookup,
    st_hit,
    st_done,
    st_miss,
    st_wb,
    st_wb_gap,
    st_wb_end,
    st_fill,
    st_fill_gap,
    st_fill_end
  } state_e;

  state_e      state_q, state_d;
  cache_addr_u req_adr;
  cache_addr_u m_adr;
  logic [1:0]  beat;
  logic        hit;

  assign req_adr = req_i.adr;
  assign beat    = cnt_i[1:0];
  assign hit     = rd_line_i.valid && (rd_line_i.tag == req_adr.f.tag);

  assign ack_o      = (state_q == st_done);
  assign status_o   = {state_q == st_hit, state_q == st_miss};
  assign ram_init_o = (state_q == st_init);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= st_init;
    end else begin
      state_q <= state_d;
    end
  end

  // ======================================================================
  // Next state and strobes
  // ======================================================================
  always_comb begin
    state_d   = state_q;
    cnt_clr_o = 1'b0;
    cnt_inc_o = 1'b0;
    op_o      = op_hold;
    ram_we_o  = 1'b0;
    m_adr     = req_adr;
    m_adr.f.word = beat;
    mreq_o    = '0;

    case (state_q)
      st_init: begin
        op_o      = op_invalidate;
        ram_we_o  = 1'b1;
        cnt_inc_o = 1'b1;  // Counts down in init
        if (cnt_last_i) begin
          state_d = st_idle;
        end
      end
      st_idle: begin
        if (req_i.cyc && req_i.stb) begin
          state_d = st_lookup;
        end
      end
      st_lookup: begin
        op_o    = op_load;
        state_d = hit ? st_hit : st_miss;
      end
      st_hit: begin
        if (req_i.we) begin
          op_o = op_merge;
        end
        state_d = st_done;
      end
      st_done: begin
        ram_we_o = req_i.we;  // Store merged line
        state_d  = st_idle;
      end
      st_miss: begin
        cnt_clr_o = 1'b1;
        state_d   = rd_line_i.valid ? st_wb : st_fill;
      end
      st_wb: begin
        m_adr.f.tag = rd_line_i.tag;  // Victim address
        if (rd_line_i.dirty[beat]) begin
          mreq_o.cyc = 1'b1;
          mreq_o.stb = 1'b1;
          mreq_o.we  = 1'b1;
          mreq_o.dat = wdat_i;
          if (mack_i) begin
            op_o    = op_clear_dirty;
            state_d = st_wb_gap;
          end
        end else if (cnt_last_i) begin
          state_d = st_wb_end;
        end else begin
          cnt_inc_o = 1'b1;  // Skip clean word
        end
      end
      st_wb_gap: begin
        if (cnt_last_i) begin
          state_d = st_wb_end;
        end else begin
          cnt_inc_o = 1'b1;
          state_d   = st_wb;
        end
      end
      st_wb_end: begin
        ram_we_o  = 1'b1;
        cnt_clr_o = 1'b1;
        state_d   = st_fill;
      end
      st_fill: begin
        mreq_o.cyc = 1'b1;
        mreq_o.stb = 1'b1;
        if (mack_i) begin
          op_o    = op_fill_word;
          state_d = st_fill_gap;
        end
      end
      st_fill_gap: begin
        if (cnt_last_i) begin
          state_d = st_fill_end;
        end else begin
          cnt_inc_o = 1'b1;
          state_d   = st_fill;
        end
      end
      st_fill_end: begin
        ram_we_o = 1'b1;
        state_d  = st_lookup;  // Retry the lookup
      end
      default: state_d = st_idle;
    endcase

    mreq_o.adr = m_adr.flat;
  end

endmodule

`default_nettype wire

/* cache/cache_line_buf.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_line_buf (
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  input  wire cache_pkg::line_op_e    op_i,
  input  wire logic [1:0]             beat_i,
  input  wire cache_pkg::sbus_req_t   req_i,
  input  wire cache_pkg::cache_line_t rd_line_i,
  input  wire logic [31:0]            mdat_i,
  output cache_pkg::cache_line_t      wr_line_o,
  output logic [31:0]                 rd_word_o,
  output logic [31:0]                 wb_word_o
);
  import cache_pkg::*;

  logic             valid_q;
  logic [3:0]       dirty_q;
  logic [tag_w-1:0] tag_q;
  logic [3:0][31:0] data_q;
  logic [1:0]       word;

  assign word = req_i.adr.f.word;

  // Line state bits
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
      dirty_q <= '0;
    end else begin
      case (op_i)
        op_load: begin
          valid_q <= rd_line_i.valid;
          dirty_q <= rd_line_i.dirty;
        end
        op_merge:       dirty_q[word] <= 1'b1;
        op_fill_word: begin
          valid_q         <= 1'b1;
          dirty_q[beat_i] <= 1'b0;  // Fresh from memory
        end
        op_clear_dirty: dirty_q[beat_i] <= 1'b0;
        op_invalidate:  valid_q <= 1'b0;
        default: ;
      endcase
    end
  end

  // ======================================================================
  // Tag and data words
  // ======================================================================
  always_ff @(posedge clk_i) begin
    case (op_i)
      op_load: begin
        tag_q  <= rd_line_i.tag;
        data_q <= rd_line_i.data;
      end
      op_merge: begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.sel[b]) begin
            data_q[word][8*b +: 8] <= req_i.dat[8*b +: 8];
          end
        end
      end
      op_fill_word: begin
        tag_q          <= req_i.adr.f.tag;
        data_q[beat_i] <= mdat_i;
      end
      default: ;
    endcase
    rd_word_o <= data_q[word];  // Valid in the ack cycle
  end

  assign wr_line_o = '{valid: valid_q, dirty: dirty_q, tag: tag_q, data: data_q};
  assign wb_word_o = data_q[beat_i];

endmodule

`default_nettype wire

/* cache/cache_line_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_line_ram (
  input  wire logic                        clk_i,
  input  wire logic                        we_i,
  input  wire logic [cache_pkg::idx_w-1:0] addr_i,
  input  wire cache_pkg::cache_line_t      wdat_i,
  output cache_pkg::cache_line_t           rdat_o
);
  import cache_pkg::*;

  cache_line_t mem [num_lines];

  // ======================================================================
  // Single port, write-first
  // ======================================================================
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[addr_i] <= wdat_i;
      rdat_o      <= wdat_i;  // New line visible on the next lookup
    end else begin
      rdat_o <= mem[addr_i];
    end
  end

endmodule

`default_nettype wire

/* common/cache_pkg.sv */
`default_nettype none

package cache_pkg;

  // ======================================================================
  // Geometry
  // ======================================================================
  localparam int addr_w    = 21;  // Word address
  localparam int idx_w     = 8;
  localparam int tag_w     = 11;
  localparam int num_lines = 256;

  // Lookup view of a word address
  typedef struct packed {
    logic [tag_w-1:0] tag;
    logic [idx_w-1:0] idx;
    logic [1:0]       word;
  } cache_addr_f_t;

  typedef union packed {
    logic [addr_w-1:0] flat;  // Master bus, memory model
    cache_addr_f_t     f;     // Tag, index, word select
  } cache_addr_u;

  // One RAM row, 144 bits
  typedef struct packed {
    logic              valid;
    logic [3:0]        dirty;  // One per word
    logic [tag_w-1:0]  tag;
    logic [3:0][31:0]  data;
  } cache_line_t;

  // ======================================================================
  // Bus bundles
  // ======================================================================
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    cache_addr_u adr;
    logic [3:0]  sel;  // Byte lanes on writes
    logic [31:0] dat;
  } sbus_req_t;

  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [addr_w-1:0] adr;
    logic [31:0]       dat;
  } mbus_req_t;

  // Line buffer commands
  typedef enum logic [2:0] {
    op_hold,
    op_load,
    op_merge,
    op_fill_word,
    op_clear_dirty,
    op_invalidate
  } line_op_e;

endpackage

`default_nettype wire

/* design/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top (
  input  wire logic                 clk_i,
  input  wire logic                 rst_i,
  input  wire cache_pkg::sbus_req_t sreq_i,
  output logic [31:0]               sdat_o,
  output logic                      sack_o,
  output logic [1:0]                status_o,
  output cache_pkg::mbus_req_t      mreq_o,
  input  wire logic [31:0]          mdat_i,
  input  wire logic                 mack_i
);
  import cache_pkg::*;

  logic [idx_w-1:0] cnt;
  logic             cnt_last;
  logic             cnt_clr;
  logic             cnt_inc;
  line_op_e         op;
  logic             ram_we;
  logic             ram_init;
  logic [idx_w-1:0] ram_addr;
  cache_line_t      rd_line;
  cache_line_t      wr_line;
  logic [31:0]      wb_word;

  assign ram_addr = ram_init ? cnt : sreq_i.adr.f.idx;  // Init row walk

  cache_ctrl i_cache_ctrl (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .req_i      (sreq_i),
    .rd_line_i  (rd_line),
    .cnt_i      (cnt),
    .cnt_last_i (cnt_last),
    .cnt_clr_o  (cnt_clr),
    .cnt_inc_o  (cnt_inc),
    .op_o       (op),
    .ram_we_o   (ram_we),
    .ram_init_o (ram_init),
    .mreq_o     (mreq_o),
    .wdat_i     (wb_word),
    .mack_i     (mack_i),
    .ack_o      (sack_o),
    .status_o   (status_o)
  );

  cache_beat_cnt i_cache_beat_cnt (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .ram_init_i (ram_init),
    .clr_i      (cnt_clr),
    .inc_i      (cnt_inc),
    .cnt_o      (cnt),
    .last_o     (cnt_last)
  );

  cache_line_buf i_cache_line_buf (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .op_i      (op),
    .beat_i    (cnt[1:0]),
    .req_i     (sreq_i),
    .rd_line_i (rd_line),
    .mdat_i    (mdat_i),
    .wr_line_o (wr_line),
    .rd_word_o (sdat_o),
    .wb_word_o (wb_word)
  );

  cache_line_ram i_cache_line_ram (
    .clk_i  (clk_i),
    .we_i   (ram_we),
    .addr_i (ram_addr),
    .wdat_i (wr_line),
    .rdat_o (rd_line)
  );

endmodule

`default_nettype wire

/* tests/cache_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_assertions (
  input wire logic                 clk_i,
  input wire logic                 rst_i,
  input wire cache_pkg::mbus_req_t mreq_i,
  input wire logic                 mack_i,
  input wire logic                 sack_i
);

  logic [8:0] init_left;

  // Row walk cycles still to come
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      init_left <= 9'd256;
    end else if (init_left != '0) begin
      init_left <= init_left - 1'b1;
    end
  end

  a_stb_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
    mreq_i.stb == mreq_i.cyc)
    else $error("master stb differs from cyc");

  a_cyc_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    (mreq_i.cyc && !mack_i) |=> mreq_i.cyc)
    else $error("master cyc dropped before ack");

  a_sack_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    sack_i |=> !sack_i)
    else $error("slave ack longer than one cycle");

  a_no_init_ack: assert property (@(posedge clk_i) disable iff (rst_i)
    (init_left != '0) |-> !sack_i)
    else $error("slave ack during init");

endmodule

`default_nettype wire

/* tests/cache_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_checker (
  input  wire logic                 clk_i,
  input  wire logic                 rst_i,
  input  wire cache_pkg::sbus_req_t sreq_i,
  input  wire logic [31:0]          sdat_i,
  input  wire logic                 sack_i,
  input  wire logic [1:0]           status_i,
  input  wire cache_pkg::mbus_req_t mreq_i,
  input  wire logic                 mack_i,
  input  wire logic                 exp_miss_i,
  input  wire logic [7:0]           exp_wb_i,
  input  wire logic [31:0]          exp_rd_i,
  input  wire logic [7:0]           test_i,
  output int                        err_cnt_o
);

  logic       active;
  logic       seen_hit;
  logic       seen_miss;
  int         lat;
  int         wb_cnt;
  int         fill_cnt;
  int         checks;
  int         test_errs;
  logic [7:0] test_q;

  task automatic note_error(input string msg);
    $display("%s", msg);
    err_cnt_o++;
    test_errs++;
  endtask

  task automatic check_ack();
    checks++;
    if (seen_miss !== exp_miss_i) begin
      note_error($sformatf("[ERROR] status_o miss expected %h got %h", exp_miss_i, seen_miss));
    end
    if (!seen_hit) begin
      note_error("Request acknowledged without a hit pulse on status_o");
    end
    if (wb_cnt != int'(exp_wb_i)) begin
      note_error($sformatf("[ERROR] mreq_o.we beats expected %h got %h", exp_wb_i, wb_cnt));
    end
    if (fill_cnt != (exp_miss_i ? 4 : 0)) begin
      note_error($sformatf("Line fill took %0d memory reads", fill_cnt));
    end
    if (!exp_miss_i && lat != 3) begin
      note_error($sformatf("Hit acknowledged after %0d cycles instead of 3", lat));
    end
    if (!sreq_i.we && sdat_i !== exp_rd_i) begin
      note_error($sformatf("[ERROR] sdat_o expected %h got %h", exp_rd_i, sdat_i));
    end
  endtask

  // Sampled mid-cycle where all DUT outputs are settled
  always @(negedge clk_i) begin
    if (rst_i) begin
      active    = 1'b0;
      err_cnt_o = 0;
      checks    = 0;
      test_errs = 0;
      test_q    = 8'd0;
    end else begin
      if (active) begin
        lat++;
        if (status_i[1]) seen_hit = 1'b1;
        if (status_i[0]) seen_miss = 1'b1;
        if (mreq_i.cyc && mack_i) begin
          if (mreq_i.we) wb_cnt++;
          else fill_cnt++;
        end
        if (sack_i) begin
          check_ack();
          active = 1'b0;
        end
      end else if (sreq_i.cyc && sreq_i.stb) begin
        active    = 1'b1;
        lat       = 0;
        seen_hit  = 1'b0;
        seen_miss = 1'b0;
        wb_cnt    = 0;
        fill_cnt  = 0;
      end
      if (test_i != test_q) begin
        if (test_q != 8'd0) begin
          $display("Test %0d finished with %0d errors", test_q, test_errs);
        end
        if (test_i == 8'd6) begin
          $display("Checks %0d, errors %0d", checks, err_cnt_o);
        end
        test_errs = 0;
        test_q    = test_i;
      end
    end
  end

endmodule

`default_nettype wire

/* tests/tb_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cache;
  import cache_pkg::*;

  localparam int timeout_cycles = 256 + 8 + 330 * 60;  // Init plus worst miss per request

  logic        clk_i;
  logic        rst_i;
  sbus_req_t   sreq;
  logic [31:0] sdat;
  logic        sack;
  logic [1:0]  status;
  mbus_req_t   mreq;
  logic [31:0] mdat;
  logic        mack;

  logic        exp_miss;
  int          exp_wb;
  logic [31:0] exp_rd;
  logic [7:0]  test_num;
  int          err_cnt;
  int          cycles;
  integer      seed;
  int          wait_left;

  logic [31:0]      mem [int];     // Main memory, written words only
  logic [31:0]      sh_mem [int];  // Shadow of what the CPU should see
  logic             sh_valid [num_lines];
  logic [tag_w-1:0] sh_tag [num_lines];
  logic [3:0]       sh_dirty [num_lines];

  cache_top i_cache_top (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .sreq_i   (sreq),
    .sdat_o   (sdat),
    .sack_o   (sack),
    .status_o (status),
    .mreq_o   (mreq),
    .mdat_i   (mdat),
    .mack_i   (mack)
  );

  cache_checker i_cache_checker (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .sreq_i     (sreq),
    .sdat_i     (sdat),
    .sack_i     (sack),
    .status_i   (status),
    .mreq_i     (mreq),
    .mack_i     (mack),
    .exp_miss_i (exp_miss),
    .exp_wb_i   (8'(exp_wb)),
    .exp_rd_i   (exp_rd),
    .test_i     (test_num),
    .err_cnt_o  (err_cnt)
  );

  bind cache_top cache_assertions i_cache_assertions (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .mreq_i (mreq_o),
    .mack_i (mack_i),
    .sack_i (sack_o)
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > timeout_cycles) begin
      $display("Timeout: run still busy after %0d cycles", cycles);
      $display("Something failed");
      $finish;
    end
  end

  // Preset memory contents
  function automatic logic [31:0] init_word(input logic [addr_w-1:0] adr);
    return {11'h0, adr} ^ 32'h3c5a_96e1;
  endfunction

  // ======================================================================
  // Reference model
  // ======================================================================
  function automatic void predict(input sbus_req_t req, output logic miss,
                                  output int wb, output logic [31:0] rd);
    cache_addr_u      a;
    int               key;
    logic [31:0]      w;
    logic [idx_w-1:0] idx;
    a    = req.adr;
    key  = int'(a.flat);
    idx  = a.f.idx;
    miss = !sh_valid[idx] || (sh_tag[idx] != a.f.tag);
    wb   = 0;
    if (miss) begin
      if (sh_valid[idx]) begin
        for (int i = 0; i < 4; i++) begin
          wb += int'(sh_dirty[idx][i]);  // Only dirty words go out
        end
      end
      sh_valid[idx] = 1'b1;
      sh_tag[idx]   = a.f.tag;
      sh_dirty[idx] = '0;
    end
    w = sh_mem.exists(key) ? sh_mem[key] : init_word(a.flat);
    if (req.we) begin
      for (int b = 0; b < 4; b++) begin
        if (req.sel[b]) begin
          w[8*b +: 8] = req.dat[8*b +: 8];
        end
      end
      sh_mem[key] = w;
      sh_dirty[idx][a.f.word] = 1'b1;
    end
    rd = w;
  endfunction

  // Memory model, ack after 1 to 3 cycles
  always @(posedge clk_i) begin : mem_model
    int          key;
    logic [31:0] r;
    #2;
    mack = 1'b0;
    if (mreq.cyc) begin
      if (wait_left == 0) begin
        r         = $random(seed);
        wait_left = 1 + int'($unsigned(r) % 3);
      end else begin
        wait_left--;
        if (wait_left == 0) begin
          key = int'(mreq.adr);
          if (mreq.we) begin
            mem[key] = mreq.dat;
          end else begin
            mdat = mem.exists(key) ? mem[key] : init_word(mreq.adr);
          end
          mack = 1'b1;
        end
      end
    end
  end

  task automatic run_req(input logic we, input logic [addr_w-1:0] adr,
                         input logic [3:0] sel, input logic [31:0] dat);
    sbus_req_t req;
    req          = '0;
    req.cyc      = 1'b1;
    req.stb      = 1'b1;
    req.we       = we;
    req.adr.flat = adr;
    req.sel      = sel;
    req.dat      = dat;
    predict(req, exp_miss, exp_wb, exp_rd);
    sreq = req;
    do @(negedge clk_i); while (!sack);
    @(posedge clk_i);
    #2;
    sreq = '0;
    @(posedge clk_i);
    #2;
  endtask

  initial begin : stimulus
    cache_addr_u a;
    cache_addr_u b;
    logic [31:0] r;
    logic [31:0] d;
    seed      = 32'h0c95_0048;
    cycles    = 0;
    wait_left = 0;
    rst_i     = 1'b1;
    sreq      = '0;
    mdat      = '0;
    mack      = 1'b0;
    exp_miss  = 1'b0;
    exp_wb    = 0;
    exp_rd    = '0;
    test_num  = 8'd0;
    for (int i = 0; i < num_lines; i++) begin
      sh_valid[i] = 1'b0;
      sh_dirty[i] = '0;
      sh_tag[i]   = '0;
    end
    repeat (8) @(posedge clk_i);
    #2;
    rst_i = 1'b0;
    a.f.tag  = 11'd1;
    a.f.idx  = 8'd5;
    a.f.word = 2'd2;
    b        = a;
    b.f.tag  = 11'd2;

    test_num = 8'd1;  // Cold read, held through the init walk
    run_req(1'b0, a.flat, 4'h0, 32'h0);
    test_num = 8'd2;  // Same line again
    a.f.word = 2'd1;
    run_req(1'b0, a.flat, 4'h0, 32'h0);
    test_num = 8'd3;
    a.f.word = 2'd2;
    run_req(1'b1, a.flat, 4'b0101, 32'hdead_beef);
    run_req(1'b1, a.flat, 4'b1000, 32'h5500_0000);
    run_req(1'b0, a.flat, 4'h0, 32'h0);
    test_num = 8'd4;  // Evict a line with two dirty words
    a.f.word = 2'd0;
    run_req(1'b1, a.flat, 4'b1111, 32'h1234_5678);
    run_req(1'b0, b.flat, 4'h0, 32'h0);
    run_req(1'b0, a.flat, 4'h0, 32'h0);
    a.f.word = 2'd2;
    run_req(1'b0, a.flat, 4'h0, 32'h0);

    test_num = 8'd5;
    for (int n = 0; n < 300; n++) begin
      r        = $random(seed);
      d        = $random(seed);
      a.f.tag  = 11'(r[1:0]);
      a.f.idx  = 8'(r[4:2]);
      a.f.word = r[6:5];
      run_req(r[7], a.flat, r[11:8], d);
    end

    test_num = 8'd6;
    repeat (2) @(posedge clk_i);
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
common/cache_pkg.sv
cache/cache_beat_cnt.sv
cache/cache_line_ram.sv
cache/cache_line_buf.sv
cache/cache_ctrl.sv
design/cache_top.sv
tests/cache_assertions.sv
tests/cache_checker.sv
tests/tb_cache.sv
